//--- ddr_rd_arbiter.sv
`timescale 1ns/100ps
`include "frame_rd_params.svh"

module ddr_rd_arbiter (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [`FR_NUM_CH-1:0]                  req,
  input  logic [`FR_NUM_CH-1:0][`FR_ADDR_W-1:0]  req_addr,
  input  logic [`FR_NUM_CH-1:0][`FR_LEN_W-1:0]   req_num,
  output logic [`FR_NUM_CH-1:0]                  gnt,
  output logic [`FR_NUM_CH-1:0]                  done,
  output logic                                   ddr_cmd_valid,
  output logic [`FR_ADDR_W-1:0]                  ddr_addr,
  output logic [`FR_LEN_W-1:0]                   ddr_num,
  input  logic                                   ddr_done
);

  localparam int NUM_CH = `FR_NUM_CH;
  localparam int IDX_W  = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

  logic             busy;
  logic [IDX_W-1:0] last;
  logic [IDX_W-1:0] owner;
  logic [IDX_W-1:0] pick;
  logic             pick_ok;
  logic             done_d0;
  logic             done_d1;
  logic             done_d2;
  logic             done_rise;

  // first requester after the last one served
  always_comb begin
    int idx;
    pick    = last;
    pick_ok = 1'b0;
    for (int i = 1; i <= NUM_CH; i++) begin
      idx = (int'(last) + i) % NUM_CH;
      if (!pick_ok && req[idx]) begin
        pick    = IDX_W'(idx);
        pick_ok = 1'b1;
      end
    end
  end

  assign gnt       = (!busy && pick_ok) ? (NUM_CH'(1) << pick) : '0;
  assign done_rise = done_d1 & ~done_d2;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy          <= 1'b0;
      last          <= IDX_W'(NUM_CH - 1);
      owner         <= '0;
      ddr_cmd_valid <= 1'b0;
      done          <= '0;
      done_d0       <= 1'b0;
      done_d1       <= 1'b0;
      done_d2       <= 1'b0;
    end else begin
      done_d0       <= ddr_done;
      done_d1       <= done_d0;
      done_d2       <= done_d1;
      ddr_cmd_valid <= 1'b0;
      done          <= '0;
      if (!busy && pick_ok) begin
        busy          <= 1'b1;
        owner         <= pick;
        last          <= pick;
        ddr_cmd_valid <= 1'b1;
      end else if (busy && done_rise) begin
        busy        <= 1'b0;
        done[owner] <= 1'b1;
      end
    end
  end

  // controller takes byte addresses
  always_ff @(posedge clk) begin
    if (!busy && pick_ok) begin
      ddr_addr <= {req_addr[pick][`FR_ADDR_W-3:0], 2'b00};
      ddr_num  <= req_num[pick];
    end
  end

  // a channel keeps its request up until it is granted
  a_req_held : assert property (@(posedge clk) disable iff (rst)
    (req & ~gnt) != '0 |=> (req & $past(req & ~gnt)) == $past(req & ~gnt));
  // the controller only completes a burst that was issued
  a_done_for_cmd : assert property (@(posedge clk) disable iff (rst) done_rise |-> busy);

endmodule

//--- frame_base_gen.sv
`timescale 1ns/100ps
`include "frame_rd_params.svh"

module frame_base_gen (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     rd_vs,
  input  logic [`FR_SLOT_W-1:0]                    wr_frame_cnt,
  input  frame_rd_pkg::rd_layout_t                 layout,
  input  logic [`FR_NUM_CH-1:0]                    ch_idle,
  output logic [`FR_NUM_CH-1:0][`FR_ADDR_W-1:0]    ch_base,
  output frame_rd_pkg::rd_layout_t                 frame_layout
);
  import frame_rd_pkg::*;

  localparam int ADDR_W = `FR_ADDR_W;
  localparam int SLOT_W = `FR_SLOT_W;
  localparam logic [ADDR_W-1:0] START     = ADDR_W'(`FR_START_ADDR);
  localparam logic [ADDR_W-1:0] BLOCK     = ADDR_W'(`FR_BLOCK_SIZE);
  localparam logic [ADDR_W-1:0] CH_REGION = ADDR_W'(`FR_CH_OFFSET * `FR_BLOCK_SIZE);

  logic              vs_d0;
  logic              vs_d1;
  logic              vs_rise;
  logic              accept;
  logic              accept_q;
  logic [SLOT_W-1:0] wr_cnt_q;
  logic [SLOT_W-1:0] slot;

  // word address of a slot inside one channel's region
  function automatic logic [ADDR_W-1:0] slot_base(input logic [SLOT_W-1:0] s, input int c);
    return START + ADDR_W'(s) * BLOCK + ADDR_W'(c) * CH_REGION;
  endfunction

  assign vs_rise = vs_d0 & ~vs_d1;
  // a new frame is only taken when no channel is mid-request
  assign accept  = vs_rise && (&ch_idle);

  always_ff @(posedge clk) begin
    if (rst) begin
      vs_d0        <= 1'b0;
      vs_d1        <= 1'b0;
      accept_q     <= 1'b0;
      slot         <= '0;
      frame_layout <= layout_split;
      for (int c = 0; c < `FR_NUM_CH; c++) begin
        ch_base[c] <= slot_base('0, c);
      end
    end else begin
      vs_d0    <= rd_vs;
      vs_d1    <= vs_d0;
      accept_q <= accept;
      if (accept) begin
        // writer is still filling wr_cnt_q, read the one before it
        slot         <= wr_cnt_q - SLOT_W'(1);
        frame_layout <= layout;
      end
      if (accept_q) begin
        for (int c = 0; c < `FR_NUM_CH; c++) begin
          ch_base[c] <= slot_base(slot, c);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    wr_cnt_q <= wr_frame_cnt;
  end

  a_base_only_on_frame : assert property (@(posedge clk) disable iff (rst)
    !accept_q |=> $stable(ch_base));

endmodule

//--- frame_rd_params.svh
`ifndef FRAME_RD_PARAMS_SVH
`define FRAME_RD_PARAMS_SVH

// ddr word address and burst length widths
`define FR_ADDR_W 30
`define FR_LEN_W 28

// read channels sharing the ddr port
`define FR_NUM_CH 2

// picture geometry
`define FR_IMAGE_H 720
`define FR_LINE_W 10
`define FR_PITCH 320
`define FR_WR_NUM 1800

// frame slot layout, in words
`define FR_BLOCK_SIZE 'h80000
`define FR_HALF_OFFSET 'h38400
`define FR_CH_OFFSET 48
`define FR_START_ADDR 0
`define FR_SLOT_W 3

`define FR_FIFO_DEPTH 8

`endif

//--- frame_rd_pkg.sv
package frame_rd_pkg;

  // read channel sequencing
  typedef enum logic [1:0] {
    ch_idle,
    ch_calc,
    ch_req,
    ch_wait
  } ch_state_t;

  // frame storage layout, picked once per frame
  // split keeps the lower half at double pitch and the upper half
  // in its own region of the slot
  typedef enum logic {
    layout_split,
    layout_linear
  } rd_layout_t;

endpackage

//--- frame_rd_top.sv
`timescale 1ns/100ps
`include "frame_rd_params.svh"

module frame_rd_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      rd_vs,
  input  logic [`FR_SLOT_W-1:0]     wr_frame_cnt,
  input  frame_rd_pkg::rd_layout_t  layout,
  input  logic [`FR_NUM_CH-1:0]     line_valid,
  input  logic [`FR_LINE_W-1:0]     line_num,
  input  logic                      ddr_done,
  output logic                      ddr_cmd_valid,
  output logic [`FR_ADDR_W-1:0]     ddr_addr,
  output logic [`FR_LEN_W-1:0]      ddr_num,
  output logic [`FR_NUM_CH-1:0]     ch_idle
);
  import frame_rd_pkg::*;

  rd_layout_t                               frame_layout;
  logic [`FR_NUM_CH-1:0][`FR_ADDR_W-1:0]    ch_base;
  logic [`FR_NUM_CH-1:0][`FR_ADDR_W-1:0]    req_addr;
  logic [`FR_NUM_CH-1:0][`FR_LEN_W-1:0]     req_num;
  logic [`FR_NUM_CH-1:0]                    req;
  logic [`FR_NUM_CH-1:0]                    gnt;
  logic [`FR_NUM_CH-1:0]                    done;

  frame_base_gen u_frame_base (
    .clk          (clk),
    .rst          (rst),
    .rd_vs        (rd_vs),
    .wr_frame_cnt (wr_frame_cnt),
    .layout       (layout),
    .ch_idle      (ch_idle),
    .ch_base      (ch_base),
    .frame_layout (frame_layout)
  );

  // one address counter per read channel
  for (genvar c = 0; c < `FR_NUM_CH; c++) begin : g_ch
    rd_addr_ctr u_ctr (
      .clk        (clk),
      .rst        (rst),
      .line_valid (line_valid[c]),
      .line_num   (line_num),
      .base       (ch_base[c]),
      .layout     (frame_layout),
      .req        (req[c]),
      .req_addr   (req_addr[c]),
      .req_num    (req_num[c]),
      .gnt        (gnt[c]),
      .done       (done[c]),
      .idle       (ch_idle[c])
    );
  end

  ddr_rd_arbiter u_arb (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .req_addr      (req_addr),
    .req_num       (req_num),
    .gnt           (gnt),
    .done          (done),
    .ddr_cmd_valid (ddr_cmd_valid),
    .ddr_addr      (ddr_addr),
    .ddr_num       (ddr_num),
    .ddr_done      (ddr_done)
  );

endmodule

//--- line_fifo.sv
`timescale 1ns/100ps
`include "frame_rd_params.svh"

module line_fifo (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  logic [`FR_LINE_W-1:0] din,
  input  logic                  pop,
  output logic [`FR_LINE_W-1:0] dout,
  output logic                  empty,
  output logic                  full
);

  localparam int DEPTH = `FR_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  logic [`FR_LINE_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [PTR_W:0]        count;
  logic                  do_push;
  logic                  do_pop;

  // pushes into a full fifo are lost
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign empty   = (count == '0);
  assign full    = (count == (PTR_W + 1)'(DEPTH));
  assign dout    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow : assert property (@(posedge clk) disable iff (rst) push |-> !full);
  a_no_underflow : assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

//--- rd_addr_ctr.sv
`timescale 1ns/100ps
`include "frame_rd_params.svh"

module rd_addr_ctr (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      line_valid,
  input  logic [`FR_LINE_W-1:0]     line_num,
  input  logic [`FR_ADDR_W-1:0]     base,
  input  frame_rd_pkg::rd_layout_t  layout,
  output logic                      req,
  output logic [`FR_ADDR_W-1:0]     req_addr,
  output logic [`FR_LEN_W-1:0]      req_num,
  input  logic                      gnt,
  input  logic                      done,
  output logic                      idle
);
  import frame_rd_pkg::*;

  localparam int LINE_W = `FR_LINE_W;
  localparam int ADDR_W = `FR_ADDR_W;
  localparam int LEN_W  = `FR_LEN_W;
  localparam logic [LINE_W-1:0] HALF_H      = LINE_W'(`FR_IMAGE_H / 2);
  localparam logic [ADDR_W-1:0] PITCH       = ADDR_W'(`FR_PITCH);
  localparam logic [ADDR_W-1:0] HALF_OFFSET = ADDR_W'(`FR_HALF_OFFSET);
  localparam logic [LEN_W-1:0]  LINE_LEN    = LEN_W'(`FR_WR_NUM);

  ch_state_t         state;
  logic              calc_step;
  logic              pop;
  logic [LINE_W-1:0] fifo_dout;
  logic              fifo_empty;
  logic [LINE_W-1:0] line_q;
  logic              upper_half;
  logic [LINE_W:0]   row;
  logic [ADDR_W-1:0] row_prod;
  logic              half_q;
  logic              dbl_q;

  line_fifo u_line_fifo (
    .clk   (clk),
    .rst   (rst),
    .push  (line_valid),
    .din   (line_num),
    .pop   (pop),
    .dout  (fifo_dout),
    .empty (fifo_empty),
    .full  ()
  );

  assign pop = (state == ch_idle) && !fifo_empty;
  assign req = (state == ch_req);

  // stored row of the line inside its region
  always_comb begin
    upper_half = (layout == layout_split) && (line_q >= HALF_H);
    if (layout == layout_linear) begin
      row = {1'b0, line_q};
    end else if (upper_half) begin
      row = {1'b0, line_q - HALF_H};
    end else begin
      // lower half sits on every other line
      row = {line_q, 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ch_idle;
      calc_step <= 1'b0;
      idle      <= 1'b1;
    end else begin
      idle <= (state == ch_idle);
      case (state)
        ch_idle: begin
          if (pop) state <= ch_calc;
        end
        ch_calc: begin
          // two steps: multiply, then add the bases
          calc_step <= !calc_step;
          if (calc_step) state <= ch_req;
        end
        ch_req: begin
          if (gnt) state <= ch_wait;
        end
        ch_wait: begin
          if (done) state <= ch_idle;
        end
        default: state <= ch_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      line_q <= fifo_dout;
    end
    if (state == ch_calc) begin
      if (!calc_step) begin
        row_prod <= ADDR_W'(row) * PITCH;
        half_q   <= upper_half;
        dbl_q    <= (layout == layout_split) && !upper_half;
      end else begin
        req_addr <= base + row_prod + (half_q ? HALF_OFFSET : '0);
        req_num  <= dbl_q ? (LINE_LEN << 1) : LINE_LEN;
      end
    end
  end

  a_addr_held : assert property (@(posedge clk) disable iff (rst) req |=> $stable(req_addr));
  a_done_in_wait : assert property (@(posedge clk) disable iff (rst) done |-> state == ch_wait);

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_frame_rd -f vlog.f --Mdir obj_dir -o sim_frame_rd > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_frame_rd > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
exit 0

//--- tb_frame_rd.sv
`timescale 1ns/100ps
`include "frame_rd_params.svh"

module tb_frame_rd;
  import frame_rd_pkg::*;

  // line entries pushed over all tests, one per channel bit
  localparam int LINES_PUSHED    = 25;
  localparam int WATCHDOG_CYCLES = LINES_PUSHED * 20 + 200;
  localparam int CMD_LATENCY     = 5;

  typedef struct packed {
    logic [`FR_ADDR_W-1:0] addr;
    logic [`FR_LEN_W-1:0]  num;
  } cmd_t;

  logic                  clk;
  logic                  rst;
  logic                  rd_vs;
  logic [`FR_SLOT_W-1:0] wr_frame_cnt;
  rd_layout_t            layout;
  logic [`FR_NUM_CH-1:0] line_valid;
  logic [`FR_LINE_W-1:0] line_num;
  logic                  ddr_done;
  logic                  ddr_cmd_valid;
  logic [`FR_ADDR_W-1:0] ddr_addr;
  logic [`FR_LEN_W-1:0]  ddr_num;
  logic [`FR_NUM_CH-1:0] ch_idle;

  cmd_t       exp_q [`FR_NUM_CH][$];
  int         ch_log[$];
  int         errors = 0;
  int         neg_cnt = 0;
  int         lv_seen = 0;
  int         last_cmd_cyc = 0;
  int         tests_ok = 0;
  int         tests_bad = 0;
  int         exp_slot = 0;
  rd_layout_t exp_layout = layout_split;
  bit         burst_open = 1'b0;

  frame_rd_top dut0 (
    .clk           (clk),
    .rst           (rst),
    .rd_vs         (rd_vs),
    .wr_frame_cnt  (wr_frame_cnt),
    .layout        (layout),
    .line_valid    (line_valid),
    .line_num      (line_num),
    .ddr_done      (ddr_done),
    .ddr_cmd_valid (ddr_cmd_valid),
    .ddr_addr      (ddr_addr),
    .ddr_num       (ddr_num),
    .ch_idle       (ch_idle)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // byte address and length of one line read
  function automatic cmd_t expected_cmd(input int line, input int ch, input int slot,
                                        input rd_layout_t lay);
    longint word;
    longint len;
    cmd_t   r;
    word = longint'(`FR_START_ADDR) + longint'(slot) * longint'(`FR_BLOCK_SIZE)
         + longint'(ch) * `FR_CH_OFFSET * longint'(`FR_BLOCK_SIZE);
    if (lay == layout_linear) begin
      word = word + longint'(line) * `FR_PITCH;
      len  = `FR_WR_NUM;
    end else if (line < `FR_IMAGE_H / 2) begin
      word = word + 2 * longint'(line) * `FR_PITCH;
      len  = 2 * `FR_WR_NUM;
    end else begin
      word = word + longint'(`FR_HALF_OFFSET) + longint'(line - `FR_IMAGE_H / 2) * `FR_PITCH;
      len  = `FR_WR_NUM;
    end
    r.addr = `FR_ADDR_W'(word * 4);
    r.num  = `FR_LEN_W'(len);
    return r;
  endfunction

  function automatic int pending_cmds();
    int n;
    n = 0;
    for (int c = 0; c < `FR_NUM_CH; c++) begin
      n += exp_q[c].size();
    end
    return n;
  endfunction

  task automatic check_addr(input string name, input logic [`FR_ADDR_W-1:0] got, exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_num(input string name, input logic [`FR_LEN_W-1:0] got, exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_idle(input string name, input logic [`FR_NUM_CH-1:0] got, exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAIL t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic push_line(input logic [`FR_NUM_CH-1:0] mask, input int line);
    @(posedge clk);
    line_valid <= mask;
    line_num   <= `FR_LINE_W'(line);
    lv_seen = neg_cnt + 1;
    for (int c = 0; c < `FR_NUM_CH; c++) begin
      if (mask[c]) begin
        exp_q[c].push_back(expected_cmd(line, c, exp_slot, exp_layout));
      end
    end
    @(posedge clk);
    line_valid <= '0;
  endtask

  // wait for every expected command and for all channels back in idle
  task automatic drain();
    @(negedge clk);
    while (pending_cmds() != 0 || ch_idle != {`FR_NUM_CH{1'b1}} || ddr_done) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  task automatic pulse_sync();
    @(posedge clk);
    rd_vs <= 1'b1;
    repeat (3) @(posedge clk);
    rd_vs <= 1'b0;
  endtask

  task automatic new_frame(input logic [`FR_SLOT_W-1:0] cnt, input rd_layout_t lay);
    drain();
    @(posedge clk);
    wr_frame_cnt <= cnt;
    layout       <= lay;
    repeat (2) @(posedge clk);
    pulse_sync();
    // reader takes the slot before the one being written
    exp_slot   = (int'(cnt) + 7) % 8;
    exp_layout = lay;
    repeat (4) @(posedge clk);
  endtask

  task automatic end_test(input int num, input string name, input int err0);
    if (errors == err0) begin
      tests_ok++;
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", num, name, errors - err0);
    end
  endtask

  // controller model, done comes back 2 to 9 cycles after each command
  initial begin : ddr_model
    int dly;
    ddr_done = 1'b0;
    void'($urandom(32'h539a));
    forever begin
      @(negedge clk);
      if (ddr_cmd_valid) begin
        dly = 2 + int'($urandom % 8);
        repeat (dly) @(posedge clk);
        ddr_done <= 1'b1;
        repeat (2) @(posedge clk);
        ddr_done <= 1'b0;
      end
    end
  end

  always @(negedge clk) begin : compare_cmds
    int ch;
    neg_cnt = neg_cnt + 1;
    if (!rst) begin
      if (ddr_done) begin
        burst_open = 1'b0;
      end
      if (ddr_cmd_valid) begin
        if (burst_open) begin
          $display("second DDR command at %0t before the previous burst completed", $time);
          errors++;
        end
        burst_open   = 1'b1;
        last_cmd_cyc = neg_cnt;
        ch = -1;
        for (int c = 0; c < `FR_NUM_CH; c++) begin
          if (ch < 0 && exp_q[c].size() > 0 && exp_q[c][0].addr == ddr_addr) begin
            ch = c;
          end
        end
        // no front entry matches, report against the first pending one
        for (int c = 0; c < `FR_NUM_CH; c++) begin
          if (ch < 0 && exp_q[c].size() > 0) begin
            ch = c;
          end
        end
        if (ch < 0) begin
          $display("DDR command at %0t while no line was pending", $time);
          errors++;
        end else begin
          check_addr("ddr_addr", ddr_addr, exp_q[ch][0].addr);
          check_num("ddr_num", ddr_num, exp_q[ch][0].num);
          void'(exp_q[ch].pop_front());
          ch_log.push_back(ch);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  initial begin : run_tests
    int err0;
    rst          = 1'b1;
    rd_vs        = 1'b0;
    wr_frame_cnt = '0;
    layout       = layout_split;
    line_valid   = '0;
    line_num     = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    err0 = errors;
    @(negedge clk);
    check_idle("ch_idle", ch_idle, {`FR_NUM_CH{1'b1}});
    repeat (10) begin
      @(negedge clk);
      if (ddr_cmd_valid) begin
        $display("ddr_cmd_valid high at %0t with no line pushed", $time);
        errors++;
      end
    end
    end_test(1, "reset state", err0);

    err0 = errors;
    new_frame(`FR_SLOT_W'(3), layout_split);
    push_line(2'b01, 5);
    drain();
    check_count("cmd latency", last_cmd_cyc - lv_seen, CMD_LATENCY);
    push_line(2'b01, 0);
    push_line(2'b01, 100);
    push_line(2'b01, 359);
    drain();
    end_test(2, "split lower half", err0);

    err0 = errors;
    push_line(2'b11, 360);
    push_line(2'b11, 719);
    push_line(2'b10, 500);
    drain();
    end_test(3, "split upper half", err0);

    err0 = errors;
    new_frame(`FR_SLOT_W'(0), layout_linear);
    push_line(2'b11, 10);
    push_line(2'b10, 719);
    push_line(2'b01, 0);
    drain();
    end_test(4, "linear new slot", err0);

    err0 = errors;
    ch_log.delete();
    for (int i = 1; i <= 4; i++) begin
      push_line(2'b11, i);
    end
    drain();
    if (ch_log.size() != 8) begin
      $display("interleave test expected 8 commands but saw %0d", ch_log.size());
      errors++;
    end
    for (int i = 1; i < ch_log.size(); i++) begin
      if (ch_log[i] == ch_log[i-1]) begin
        $display("channel %0d served twice in a row at command %0d", ch_log[i], i);
        errors++;
      end
    end
    end_test(5, "two channel interleave", err0);

    err0 = errors;
    @(posedge clk);
    wr_frame_cnt <= `FR_SLOT_W'(5);
    layout       <= layout_split;
    push_line(2'b01, 20);
    @(negedge clk);
    while (ch_idle[0]) begin
      @(negedge clk);
    end
    // channel 0 busy here, this sync edge must not be taken
    pulse_sync();
    drain();
    push_line(2'b11, 21);
    drain();
    new_frame(`FR_SLOT_W'(5), layout_split);
    push_line(2'b01, 30);
    drain();
    end_test(6, "sync while busy", err0);

    $display("summary: %0d tests ok, %0d tests with errors, %0d check errors",
             tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+.
frame_rd_pkg.sv
line_fifo.sv
frame_base_gen.sv
rd_addr_ctr.sv
ddr_rd_arbiter.sv
frame_rd_top.sv
tb_frame_rd.sv
